/* dbg_overlay_config.svh */
`ifndef DBG_OVERLAY_CONFIG_SVH
`define DBG_OVERLAY_CONFIG_SVH

// Screen coordinate width, enough for 1024 columns or rows
`define DBG_COORD_W 10

// One colour channel
`define DBG_COLOR_W 8

// Number of hex byte readouts in the band
`define DBG_HEX_BYTES 8

// Glyph cell size in pixels
`define DBG_CHAR_W 8
`define DBG_CHAR_H 8

// Top left corner of the text band
`define DBG_X_OFFSET 16
`define DBG_Y_OFFSET 24

// Blank columns after each two-glyph readout
`define DBG_FIELD_GAP 8

`endif

/* dbg_overlay_pkg.sv */
`include "dbg_overlay_config.svh"

package dbg_overlay_pkg;

    // Screen position, used for both x and y
    typedef logic [`DBG_COORD_W-1:0] coord_t;

    // One colour channel of a pixel
    typedef logic [`DBG_COLOR_W-1:0] color_t;

    // A displayed byte and one of its hex digits
    typedef logic [7:0] hex_byte_t;
    typedef logic [3:0] nibble_t;

    // Readout number, 0 to 7
    typedef logic [2:0] field_idx_t;

    // Column or row inside an 8x8 glyph
    typedef logic [2:0] glyph_pos_t;

    // One row of font pixels, bit 0 is the leftmost pixel
    typedef logic [7:0] glyph_row_t;

    // What the current pixel falls on inside the band
    typedef enum logic [1:0] {
        CELL_NONE = 2'd0,
        CELL_HIGH = 2'd1,
        CELL_LOW  = 2'd2,
        CELL_GAP  = 2'd3
    } cell_kind_t;

endpackage

/* hex_font_rom.sv */
`timescale 1ns/100ps

module hex_font_rom (
    input  dbg_overlay_pkg::nibble_t    nibble_i,
    input  dbg_overlay_pkg::glyph_pos_t row_i,
    output dbg_overlay_pkg::glyph_row_t row_bits_o
);

    // Whole glyph for the selected digit
    // Row 0 sits in the top byte, row 7 in the bottom byte
    logic [63:0] glyph;

    always_comb begin
        case (nibble_i)
            4'h0:    glyph = 64'h1C22322A26221C00;
            4'h1:    glyph = 64'h080C080808081C00;
            4'h2:    glyph = 64'h1C22201804023E00;
            4'h3:    glyph = 64'h3E20101820221C00;
            4'h4:    glyph = 64'h101814123E101000;
            4'h5:    glyph = 64'h3E021E2020221C00;
            4'h6:    glyph = 64'h3804021E22221C00;
            4'h7:    glyph = 64'h3E20100804040400;
            4'h8:    glyph = 64'h1C22221C22221C00;
            4'h9:    glyph = 64'h1C22223C20100E00;
            4'hA:    glyph = 64'h081422223E222200;
            4'hB:    glyph = 64'h1E22221E22221E00;
            4'hC:    glyph = 64'h1C22020202221C00;
            4'hD:    glyph = 64'h1E22222222221E00;
            4'hE:    glyph = 64'h3E02021E02023E00;
            default: glyph = 64'h3E02021E02020200;
        endcase
    end

    // Inverted row number is 7 - row, so row 0 picks the top byte
    assign row_bits_o = glyph[{~row_i, 3'b000} +: 8];

endmodule

/* overlay_locator.sv */
`timescale 1ns/100ps
`include "dbg_overlay_config.svh"

module overlay_locator (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        enable_i,
    input  dbg_overlay_pkg::coord_t     screen_x_i,
    input  dbg_overlay_pkg::coord_t     screen_y_i,
    output dbg_overlay_pkg::field_idx_t field_idx_o,
    output dbg_overlay_pkg::cell_kind_t cell_kind_o,
    output dbg_overlay_pkg::glyph_pos_t glyph_col_o,
    output dbg_overlay_pkg::glyph_pos_t glyph_row_o
);

    // Position relative to the band corner, wraps when left of or above it
    dbg_overlay_pkg::coord_t rel_x;
    dbg_overlay_pkg::coord_t rel_y;

    // Offset inside the 24 column readout pitch
    dbg_overlay_pkg::coord_t pitch_pos;

    logic in_band;

    // Next values for the stage 1 registers
    dbg_overlay_pkg::field_idx_t field_idx_d;
    dbg_overlay_pkg::cell_kind_t cell_kind_d;
    dbg_overlay_pkg::glyph_pos_t glyph_col_d;
    dbg_overlay_pkg::glyph_pos_t glyph_row_d;

    always_comb begin
        rel_x = screen_x_i - dbg_overlay_pkg::coord_t'(`DBG_X_OFFSET);
        rel_y = screen_y_i - dbg_overlay_pkg::coord_t'(`DBG_Y_OFFSET);

        // Both lower bounds are tested on the raw coordinate
        // Upper bounds on the relative one
        in_band = (screen_x_i >= dbg_overlay_pkg::coord_t'(`DBG_X_OFFSET))
               && (screen_y_i >= dbg_overlay_pkg::coord_t'(`DBG_Y_OFFSET))
               && (rel_y < dbg_overlay_pkg::coord_t'(`DBG_CHAR_H))
               && (rel_x < dbg_overlay_pkg::coord_t'(
                      `DBG_HEX_BYTES * (2 * `DBG_CHAR_W + `DBG_FIELD_GAP)));

        // Pitch is two glyphs plus the gap
        field_idx_d = dbg_overlay_pkg::field_idx_t'(
            rel_x / dbg_overlay_pkg::coord_t'(2 * `DBG_CHAR_W + `DBG_FIELD_GAP));
        pitch_pos = rel_x % dbg_overlay_pkg::coord_t'(2 * `DBG_CHAR_W + `DBG_FIELD_GAP);

        // Column inside the glyph, glyphs start on 8 pixel boundaries
        glyph_col_d = dbg_overlay_pkg::glyph_pos_t'(
            rel_x % dbg_overlay_pkg::coord_t'(`DBG_CHAR_W));
        glyph_row_d = dbg_overlay_pkg::glyph_pos_t'(rel_y);

        // Disabled overlay looks the same as a pixel outside the band
        if (!enable_i || !in_band) begin
            cell_kind_d = dbg_overlay_pkg::CELL_NONE;
        end else if (pitch_pos < dbg_overlay_pkg::coord_t'(`DBG_CHAR_W)) begin
            cell_kind_d = dbg_overlay_pkg::CELL_HIGH;
        end else if (pitch_pos < dbg_overlay_pkg::coord_t'(2 * `DBG_CHAR_W)) begin
            cell_kind_d = dbg_overlay_pkg::CELL_LOW;
        end else begin
            cell_kind_d = dbg_overlay_pkg::CELL_GAP;
        end
    end

    // Stage 1 registers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            field_idx_o <= '0;
            cell_kind_o <= dbg_overlay_pkg::CELL_NONE;
            glyph_col_o <= '0;
            glyph_row_o <= '0;
        end else begin
            field_idx_o <= field_idx_d;
            cell_kind_o <= cell_kind_d;
            glyph_col_o <= glyph_col_d;
            glyph_row_o <= glyph_row_d;
        end
    end

endmodule

/* hex_field_render.sv */
`timescale 1ns/100ps

module hex_field_render #(
    parameter int FIELD_IDX = 0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  dbg_overlay_pkg::hex_byte_t  hex_value_i,
    input  dbg_overlay_pkg::field_idx_t field_idx_i,
    input  dbg_overlay_pkg::cell_kind_t cell_kind_i,
    input  dbg_overlay_pkg::glyph_pos_t glyph_col_i,
    input  dbg_overlay_pkg::glyph_pos_t glyph_row_i,
    output logic                        hit_o
);

    // This readout owns the pixel and it lies on one of its two glyphs
    logic field_sel;

    dbg_overlay_pkg::nibble_t    nibble;
    dbg_overlay_pkg::glyph_row_t row_bits;

    always_comb begin
        field_sel = (field_idx_i == dbg_overlay_pkg::field_idx_t'(FIELD_IDX))
                 && ((cell_kind_i == dbg_overlay_pkg::CELL_HIGH)
                  || (cell_kind_i == dbg_overlay_pkg::CELL_LOW));

        // First glyph shows the upper digit
        if (cell_kind_i == dbg_overlay_pkg::CELL_HIGH) begin
            nibble = hex_value_i[7:4];
        end else begin
            nibble = hex_value_i[3:0];
        end
    end

    hex_font_rom u_font (
        .nibble_i   (nibble),
        .row_i      (glyph_row_i),
        .row_bits_o (row_bits)
    );

    // Stage 2 register, bit 0 of the font row is the leftmost pixel
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= field_sel && row_bits[glyph_col_i];
        end
    end

endmodule

/* overlay_mixer.sv */
`timescale 1ns/100ps
`include "dbg_overlay_config.svh"

module overlay_mixer (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [`DBG_HEX_BYTES-1:0]     hit_i,
    input  dbg_overlay_pkg::color_t       r_i,
    input  dbg_overlay_pkg::color_t       g_i,
    input  dbg_overlay_pkg::color_t       b_i,
    output dbg_overlay_pkg::color_t       r_o,
    output dbg_overlay_pkg::color_t       g_o,
    output dbg_overlay_pkg::color_t       b_o
);

    // Video delay, lines up with locator and renderer stages
    dbg_overlay_pkg::color_t r_d1, g_d1, b_d1;
    dbg_overlay_pkg::color_t r_d2, g_d2, b_d2;

    // Any renderer lighting this pixel
    logic any_hit;

    assign any_hit = |hit_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_d1 <= '0;
            g_d1 <= '0;
            b_d1 <= '0;
            r_d2 <= '0;
            g_d2 <= '0;
            b_d2 <= '0;
            r_o  <= '0;
            g_o  <= '0;
            b_o  <= '0;
        end else begin
            r_d1 <= r_i;
            g_d1 <= g_i;
            b_d1 <= b_i;
            r_d2 <= r_d1;
            g_d2 <= g_d1;
            b_d2 <= b_d1;
            // White text drawn over the picture
            r_o  <= any_hit ? '1 : r_d2;
            g_o  <= any_hit ? '1 : g_d2;
            b_o  <= any_hit ? '1 : b_d2;
        end
    end

endmodule

/* debug_overlay.sv */
`timescale 1ns/100ps
`include "dbg_overlay_config.svh"

module debug_overlay (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       enable_i,
    input  dbg_overlay_pkg::coord_t    screen_x_i,
    input  dbg_overlay_pkg::coord_t    screen_y_i,
    input  dbg_overlay_pkg::hex_byte_t hex_values_i [`DBG_HEX_BYTES],
    input  dbg_overlay_pkg::color_t    r_i,
    input  dbg_overlay_pkg::color_t    g_i,
    input  dbg_overlay_pkg::color_t    b_i,
    output dbg_overlay_pkg::color_t    r_o,
    output dbg_overlay_pkg::color_t    g_o,
    output dbg_overlay_pkg::color_t    b_o
);

    // Stage 1 decode, shared by every renderer
    dbg_overlay_pkg::field_idx_t field_idx;
    dbg_overlay_pkg::cell_kind_t cell_kind;
    dbg_overlay_pkg::glyph_pos_t glyph_col;
    dbg_overlay_pkg::glyph_pos_t glyph_row;

    // Stage 2 result, one bit per readout
    logic [`DBG_HEX_BYTES-1:0] field_hit;

    overlay_locator u_locator (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .screen_x_i  (screen_x_i),
        .screen_y_i  (screen_y_i),
        .field_idx_o (field_idx),
        .cell_kind_o (cell_kind),
        .glyph_col_o (glyph_col),
        .glyph_row_o (glyph_row)
    );

    // One renderer per readout, each watches for its own index
    for (genvar i = 0; i < `DBG_HEX_BYTES; i++) begin : g_field
        hex_field_render #(
            .FIELD_IDX (i)
        ) u_render (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .hex_value_i (hex_values_i[i]),
            .field_idx_i (field_idx),
            .cell_kind_i (cell_kind),
            .glyph_col_i (glyph_col),
            .glyph_row_i (glyph_row),
            .hit_o       (field_hit[i])
        );
    end

    // Video goes straight in, delay lives in the mixer
    overlay_mixer u_mixer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hit_i   (field_hit),
        .r_i     (r_i),
        .g_i     (g_i),
        .b_i     (b_i),
        .r_o     (r_o),
        .g_o     (g_o),
        .b_o     (b_o)
    );

endmodule

/* debug_overlay_properties.sv */
`timescale 1ns/100ps
`include "dbg_overlay_config.svh"

module debug_overlay_properties (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic                       enable_i,
    input dbg_overlay_pkg::coord_t    screen_x_i,
    input dbg_overlay_pkg::coord_t    screen_y_i,
    input dbg_overlay_pkg::hex_byte_t hex_values_i [`DBG_HEX_BYTES],
    input dbg_overlay_pkg::color_t    r_i,
    input dbg_overlay_pkg::color_t    g_i,
    input dbg_overlay_pkg::color_t    b_i,
    input dbg_overlay_pkg::color_t    r_out_i,
    input dbg_overlay_pkg::color_t    g_out_i,
    input dbg_overlay_pkg::color_t    b_out_i
);

    // Two glyphs plus the gap, and the full band width
    localparam int PITCH  = 2 * `DBG_CHAR_W + `DBG_FIELD_GAP;
    localparam int BAND_W = `DBG_HEX_BYTES * PITCH;

    // Reference glyphs with row 0 first and bit 0 as the leftmost pixel
    localparam logic [7:0] FONT [16][8] = '{
        '{8'h1C, 8'h22, 8'h32, 8'h2A, 8'h26, 8'h22, 8'h1C, 8'h00},
        '{8'h08, 8'h0C, 8'h08, 8'h08, 8'h08, 8'h08, 8'h1C, 8'h00},
        '{8'h1C, 8'h22, 8'h20, 8'h18, 8'h04, 8'h02, 8'h3E, 8'h00},
        '{8'h3E, 8'h20, 8'h10, 8'h18, 8'h20, 8'h22, 8'h1C, 8'h00},
        '{8'h10, 8'h18, 8'h14, 8'h12, 8'h3E, 8'h10, 8'h10, 8'h00},
        '{8'h3E, 8'h02, 8'h1E, 8'h20, 8'h20, 8'h22, 8'h1C, 8'h00},
        '{8'h38, 8'h04, 8'h02, 8'h1E, 8'h22, 8'h22, 8'h1C, 8'h00},
        '{8'h3E, 8'h20, 8'h10, 8'h08, 8'h04, 8'h04, 8'h04, 8'h00},
        '{8'h1C, 8'h22, 8'h22, 8'h1C, 8'h22, 8'h22, 8'h1C, 8'h00},
        '{8'h1C, 8'h22, 8'h22, 8'h3C, 8'h20, 8'h10, 8'h0E, 8'h00},
        '{8'h08, 8'h14, 8'h22, 8'h22, 8'h3E, 8'h22, 8'h22, 8'h00},
        '{8'h1E, 8'h22, 8'h22, 8'h1E, 8'h22, 8'h22, 8'h1E, 8'h00},
        '{8'h1C, 8'h22, 8'h02, 8'h02, 8'h02, 8'h22, 8'h1C, 8'h00},
        '{8'h1E, 8'h22, 8'h22, 8'h22, 8'h22, 8'h22, 8'h1E, 8'h00},
        '{8'h3E, 8'h02, 8'h02, 8'h1E, 8'h02, 8'h02, 8'h3E, 8'h00},
        '{8'h3E, 8'h02, 8'h02, 8'h1E, 8'h02, 8'h02, 8'h02, 8'h00}
    };

    // Input history where index 0 holds the newest edge
    dbg_overlay_pkg::coord_t    x_h [3];
    dbg_overlay_pkg::coord_t    y_h [3];
    logic                       en_h [3];
    dbg_overlay_pkg::color_t    r_h [3];
    dbg_overlay_pkg::color_t    g_h [3];
    dbg_overlay_pkg::color_t    b_h [3];
    // Bytes are needed only one edge deep
    dbg_overlay_pkg::hex_byte_t hex_h [2][`DBG_HEX_BYTES];

    // Count of edges since reset release that saturates at 3
    logic [1:0] since_rst;

    int         rel_x;
    int         rel_y;
    int         pitch_pos;
    logic       in_band;
    logic [2:0] field;
    logic [2:0] row;
    logic [2:0] col;
    logic [3:0] digit;
    logic       lit;
    logic       blank;

    dbg_overlay_pkg::color_t exp_r;
    dbg_overlay_pkg::color_t exp_g;
    dbg_overlay_pkg::color_t exp_b;

    // One counter per check and their sum for the testbench
    int unsigned fail_reset = 0;
    int unsigned fail_r     = 0;
    int unsigned fail_g     = 0;
    int unsigned fail_b     = 0;
    int unsigned fail_blank = 0;
    int unsigned fail_total;

    assign fail_total = fail_reset + fail_r + fail_g + fail_b + fail_blank;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            since_rst <= 2'd0;
            for (int i = 0; i < 3; i++) begin
                x_h[i]  <= '0;
                y_h[i]  <= '0;
                en_h[i] <= 1'b0;
                r_h[i]  <= '0;
                g_h[i]  <= '0;
                b_h[i]  <= '0;
            end
            for (int j = 0; j < `DBG_HEX_BYTES; j++) begin
                hex_h[0][j] <= '0;
                hex_h[1][j] <= '0;
            end
        end else begin
            if (since_rst != 2'd3) begin
                since_rst <= since_rst + 2'd1;
            end
            x_h[0]   <= screen_x_i;
            y_h[0]   <= screen_y_i;
            en_h[0]  <= enable_i;
            r_h[0]   <= r_i;
            g_h[0]   <= g_i;
            b_h[0]   <= b_i;
            hex_h[0] <= hex_values_i;
            hex_h[1] <= hex_h[0];
            for (int i = 1; i < 3; i++) begin
                x_h[i]   <= x_h[i-1];
                y_h[i]   <= y_h[i-1];
                en_h[i]  <= en_h[i-1];
                r_h[i]   <= r_h[i-1];
                g_h[i]   <= g_h[i-1];
                b_h[i]   <= b_h[i-1];
            end
        end
    end

    // Output at this negedge belongs to the pixel two edges back
    // Its bytes were taken one edge later
    always_comb begin
        rel_x     = int'(x_h[2]) - `DBG_X_OFFSET;
        rel_y     = int'(y_h[2]) - `DBG_Y_OFFSET;
        in_band   = (rel_x >= 0) && (rel_x < BAND_W) && (rel_y >= 0) && (rel_y < `DBG_CHAR_H);
        field     = in_band ? 3'(rel_x / PITCH) : 3'd0;
        pitch_pos = in_band ? rel_x % PITCH : 0;
        row       = 3'(rel_y);
        col       = 3'(rel_x % `DBG_CHAR_W);
        // High digit on the first glyph of the readout
        digit     = (pitch_pos < `DBG_CHAR_W) ? hex_h[1][field][7:4] : hex_h[1][field][3:0];
        lit       = en_h[2] && in_band && (pitch_pos < 2 * `DBG_CHAR_W)
                 && FONT[digit][row][col];
        blank     = !en_h[2] || !in_band || (pitch_pos >= 2 * `DBG_CHAR_W) || (row == 3'd7);
        exp_r     = lit ? 8'hFF : r_h[2];
        exp_g     = lit ? 8'hFF : g_h[2];
        exp_b     = lit ? 8'hFF : b_h[2];
    end

    // Outputs stay black in reset and for three edges after it
    a_reset_zero: assert property (@(negedge clk_i)
        (!rst_n_i || since_rst != 2'd3) |-> (r_out_i == '0 && g_out_i == '0 && b_out_i == '0))
    else begin
        $error("Error r_o/g_o/b_o expected 000000 actual %02h%02h%02h",
               r_out_i, g_out_i, b_out_i);
        fail_reset++;
    end

    a_red: assert property (@(negedge clk_i) disable iff (!rst_n_i) r_out_i == exp_r)
    else begin
        $error("Error r_o expected %02h actual %02h", exp_r, r_out_i);
        fail_r++;
    end

    a_green: assert property (@(negedge clk_i) disable iff (!rst_n_i) g_out_i == exp_g)
    else begin
        $error("Error g_o expected %02h actual %02h", exp_g, g_out_i);
        fail_g++;
    end

    a_blue: assert property (@(negedge clk_i) disable iff (!rst_n_i) b_out_i == exp_b)
    else begin
        $error("Error b_o expected %02h actual %02h", exp_b, b_out_i);
        fail_b++;
    end

    // Gaps, row 7, disabled pixels and the area outside the band show video only
    a_blank_pass: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        blank |-> (r_out_i == r_h[2] && g_out_i == g_h[2] && b_out_i == b_h[2]))
    else begin
        $error("Error r_o/g_o/b_o on blank pixel expected %02h%02h%02h actual %02h%02h%02h",
               r_h[2], g_h[2], b_h[2], r_out_i, g_out_i, b_out_i);
        fail_blank++;
    end

endmodule

/* tb_debug_overlay.sv */
`timescale 1ns/100ps
`include "dbg_overlay_config.svh"

module tb_debug_overlay;

    // Four scans of about 3,600 pixels plus idle gaps
    localparam int TIMEOUT_CYCLES = 20000;

    logic                       clk;
    logic                       rst_n;
    logic                       enable;
    dbg_overlay_pkg::coord_t    screen_x;
    dbg_overlay_pkg::coord_t    screen_y;
    dbg_overlay_pkg::hex_byte_t hex_vals [`DBG_HEX_BYTES];
    dbg_overlay_pkg::color_t    r_in;
    dbg_overlay_pkg::color_t    g_in;
    dbg_overlay_pkg::color_t    b_in;
    dbg_overlay_pkg::color_t    r_out;
    dbg_overlay_pkg::color_t    g_out;
    dbg_overlay_pkg::color_t    b_out;

    int cycle_count = 0;

    debug_overlay u_debug_overlay (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .enable_i     (enable),
        .screen_x_i   (screen_x),
        .screen_y_i   (screen_y),
        .hex_values_i (hex_vals),
        .r_i          (r_in),
        .g_i          (g_in),
        .b_i          (b_in),
        .r_o          (r_out),
        .g_o          (g_out),
        .b_o          (b_out)
    );

    // Checker sees every DUT port
    bind debug_overlay debug_overlay_properties u_props (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .enable_i     (enable_i),
        .screen_x_i   (screen_x_i),
        .screen_y_i   (screen_y_i),
        .hex_values_i (hex_values_i),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .r_out_i      (r_o),
        .g_out_i      (g_o),
        .b_out_i      (b_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Idle pixels sit at the screen corner with random colour
    task automatic idle_pixels(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            screen_x <= '0;
            screen_y <= '0;
            enable   <= 1'b1;
            r_in     <= 8'($urandom);
            g_in     <= 8'($urandom);
            b_in     <= 8'($urandom);
        end
    endtask

    // New bytes with three quiet cycles on each side
    task automatic change_bytes(input logic all_digits);
        idle_pixels(3);
        @(posedge clk);
        for (int k = 0; k < `DBG_HEX_BYTES; k++) begin
            // 01, 23, 45 and so on up to EF
            hex_vals[k] <= all_digits ? 8'((2 * k) * 16 + 2 * k + 1) : 8'($urandom);
        end
        idle_pixels(3);
    endtask

    // Raster over the band and a margin around it
    task automatic scan_band(input logic random_enable);
        for (int y = 20; y <= 35; y++) begin
            for (int x = 0; x <= 220; x++) begin
                @(posedge clk);
                screen_x <= 10'(x);
                screen_y <= 10'(y);
                enable   <= random_enable ? 1'($urandom) : 1'b1;
                r_in     <= 8'($urandom);
                g_in     <= 8'($urandom);
                b_in     <= 8'($urandom);
            end
        end
    endtask

    initial begin
        void'($urandom(87));
        rst_n    = 1'b0;
        enable   = 1'b0;
        screen_x = '0;
        screen_y = '0;
        r_in     = '0;
        g_in     = '0;
        b_in     = '0;
        for (int k = 0; k < `DBG_HEX_BYTES; k++) begin
            hex_vals[k] = '0;
        end
        // Random video during reset must not reach the outputs
        repeat (2) begin
            @(posedge clk);
            r_in <= 8'($urandom);
            g_in <= 8'($urandom);
            b_in <= 8'($urandom);
        end
        rst_n <= 1'b1;
        // Outputs must stay black while live video starts after release
        idle_pixels(4);
        // Random bytes with the overlay on
        change_bytes(1'b0);
        scan_band(1'b0);
        // All sixteen digits
        change_bytes(1'b1);
        scan_band(1'b0);
        // Enable toggles per pixel
        scan_band(1'b1);
        // Fresh bytes must show up in the last scan
        change_bytes(1'b0);
        scan_band(1'b0);
        // Let the last pixels leave the pipeline
        idle_pixels(4);
        @(posedge clk);
        if (u_debug_overlay.u_props.fail_total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Stop at the first failed check
    initial begin
        wait (u_debug_overlay.u_props.fail_total != 0);
        $display("FAIL: see errors above");
        $fatal(1, "Stopping after the first failed check");
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped by the cycle limit");
    end

endmodule

/* flist.f */
+incdir+.
dbg_overlay_pkg.sv
hex_font_rom.sv
overlay_locator.sv
hex_field_render.sv
overlay_mixer.sv
debug_overlay.sv
debug_overlay_properties.sv
tb_debug_overlay.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the overlay testbench with Verilator
LOG=sim.log
rm -f "$LOG"

# Error limit lets the testbench report the first failure itself
verilator --binary --timing --assert --top-module tb_debug_overlay \
    -f flist.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
cat "$LOG" 2>/dev/null || cat build.log

grep -q "FAIL: see errors above" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" "$LOG" || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
